// File: Makefile
# Verilator build and run of the registration unit testbench
VERILATOR := verilator
FLAGS     := --binary --timing --assert -Wno-fatal
TOP       := oflow_registration_tb
FILELIST  := oflow_reg.f
RUN_ARGS  := +verilator+error+limit+1000
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); exit $$status
	@if grep -q "Test FAILED" $(LOG); then echo "simulation reported failure"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: hdl/oflow_feature_mem.sv
/* single-port feature store of the current frame,
   sync write, registered read */
module oflow_feature_mem (
	input  logic                                 clk,
	input  logic                                 rst_n,
	input  logic                                 we,
	input  logic [oflow_feature_pkg::row_len-1:0] addr,
	input  oflow_feature_pkg::feature_t          wdata,
	output oflow_feature_pkg::feature_t          rdata
);
	import oflow_feature_pkg::*;

	// --------------------------------------------------
	// storage
	// --------------------------------------------------
	feature_t mem [max_rows];   // one object per row

	// write port, no reset on contents
	always_ff @(posedge clk) begin
		if (we) begin
			mem[addr] <= wdata;
		end
	end

	// read register, old data on a write cycle
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rdata <= '0;
		end else begin
			rdata <= mem[addr];   // one cycle read latency
		end
	end

endmodule

// File: hdl/oflow_feature_pkg.sv
/* object feature field widths, row addressing,
   current-frame feature record and history entry */
package oflow_feature_pkg;

	// --------------------------------------------------
	// feature field widths
	// --------------------------------------------------
	localparam int cm_len    = 9;   // centre of mass, per axis (x, y)
	localparam int dim_len   = 8;   // bounding box width / height
	localparam int color_len = 8;   // dominant colour channels

	// id of a tracked object, must equal oflow_score_pkg::id_len
	localparam int id_len = 6;

	// rows of the feature store, one per set
	localparam int row_len  = 3;
	localparam int max_rows = 8;    // 2**row_len

	// --------------------------------------------------
	// records
	// --------------------------------------------------

	// features of one detected object
	typedef struct packed {
		logic [cm_len-1:0]    cm_x;     // centre x
		logic [cm_len-1:0]    cm_y;     // centre y
		logic [dim_len-1:0]   width;
		logic [dim_len-1:0]   height;
		logic [color_len-1:0] color1;   // first colour
		logic [color_len-1:0] color2;   // second colour
	} feature_t;

	// previous-frame object as streamed from the history source
	typedef struct packed {
		feature_t          feat;
		logic [id_len-1:0] id;          // id it carried last frame
	} hist_entry_t;

endpackage

// File: hdl/oflow_registration.sv
/* registration unit top: feature store, score calc,
   score board and sequencer */
module oflow_registration (
	input  logic                                       clk,
	input  logic                                       rst_n,
	input  oflow_score_pkg::weights_t                  weights,
	// command from the core
	input  logic                                       reg_req,
	output logic                                       reg_ack,
	input  oflow_feature_pkg::feature_t                cur_obj,
	input  logic [oflow_feature_pkg::row_len-1:0]      row,
	input  logic [oflow_score_pkg::frame_num_len-1:0]  frame_num,
	// history source
	input  logic                                       hist_req,
	input  oflow_feature_pkg::hist_entry_t             hist_entry,
	input  logic                                       hist_last,
	output logic                                       hist_ack,
	// CR agent
	input  logic [oflow_feature_pkg::row_len-1:0]      cr_rd_row,
	output oflow_score_pkg::board_row_t                cr_rd_data,
	input  logic                                       cr_we,
	input  logic [oflow_feature_pkg::row_len-1:0]      cr_wr_row,
	input  logic                                       cr_fallback,
	// feature readback
	input  logic [oflow_feature_pkg::row_len-1:0]      fe_rd_row,
	output oflow_feature_pkg::feature_t                fe_rd_data
);
	import oflow_feature_pkg::*;
	import oflow_score_pkg::*;

	// --------------------------------------------------
	// internal signals
	// --------------------------------------------------
	logic               mem_we;
	logic [row_len-1:0] mem_addr;
	logic               calc_start;
	logic               calc_done;
	cand_t              best;
	cand_t              second;
	logic               board_we;
	board_row_t         board_row;

	assign mem_addr = mem_we ? row : fe_rd_row;   // readback shares the port

	oflow_feature_mem oflow_feature_mem_i (
		.clk(clk), .rst_n(rst_n), .we(mem_we), .addr(mem_addr),
		.wdata(cur_obj), .rdata(fe_rd_data)
	);

	oflow_score_calc oflow_score_calc_i (
		.clk(clk), .rst_n(rst_n), .start(calc_start), .cur_obj(cur_obj),
		.weights(weights), .hist_req(hist_req), .hist_entry(hist_entry),
		.hist_last(hist_last), .hist_ack(hist_ack), .done(calc_done),
		.best(best), .second(second)
	);

	oflow_score_board oflow_score_board_i (
		.clk(clk), .rst_n(rst_n), .we(board_we), .wr_row(row), .wr_data(board_row),
		.cr_we(cr_we), .cr_wr_row(cr_wr_row), .cr_fallback(cr_fallback),
		.cr_rd_row(cr_rd_row), .cr_rd_data(cr_rd_data)
	);

	oflow_registration_fsm oflow_registration_fsm_i (
		.clk(clk), .rst_n(rst_n), .reg_req(reg_req), .reg_ack(reg_ack),
		.frame_num(frame_num), .cur_row(row), .mem_we(mem_we),
		.calc_start(calc_start), .calc_done(calc_done), .best(best),
		.second(second), .board_we(board_we), .board_row(board_row)
	);

endmodule

// File: hdl/oflow_registration_fsm.sv
/* registration sequencer: feature write, scoring, board commit,
   command handshake and first-frame id counter */
module oflow_registration_fsm (
	input  logic                                        clk,
	input  logic                                        rst_n,
	input  logic                                        reg_req,
	output logic                                        reg_ack,
	input  logic [oflow_score_pkg::frame_num_len-1:0]   frame_num,
	input  logic [oflow_feature_pkg::row_len-1:0]       cur_row,
	output logic                                        mem_we,
	output logic                                        calc_start,
	input  logic                                        calc_done,
	input  oflow_score_pkg::cand_t                      best,
	input  oflow_score_pkg::cand_t                      second,
	output logic                                        board_we,
	output oflow_score_pkg::board_row_t                 board_row
);
	import oflow_score_pkg::*;

	typedef enum logic [2:0] {
		st_idle,
		st_write,    // feature store write
		st_score,    // wait for score calc
		st_commit,   // board row write
		st_ack       // hold ack until req drops
	} state_t;

	state_t                              state;
	state_t                              next_state;
	logic                                first_frame;
	logic [oflow_score_pkg::id_len-1:0]  id_cnt;   // last id handed out

	assign first_frame = (frame_num == '0);   // no history on frame 0

	// --------------------------------------------------
	// state register and next state
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n)
			state <= st_idle;
		else
			state <= next_state;
	end

	always_comb begin
		next_state = state;
		case (state)
			st_idle:   if (reg_req) next_state = st_write;
			st_write:  next_state = first_frame ? st_commit : st_score;
			st_score:  if (calc_done) next_state = st_commit;
			st_commit: next_state = st_ack;
			st_ack:    if (!reg_req) next_state = st_idle;
			default:   next_state = st_idle;
		endcase
	end

	// moore outputs
	assign mem_we     = (state == st_write);
	assign calc_start = (state == st_write) && !first_frame;
	assign board_we   = (state == st_commit);
	assign reg_ack    = (state == st_ack);

	// first-frame ids, post incremented
	always_ff @(posedge clk) begin
		if (!rst_n)
			id_cnt <= '0;
		else if (board_we && first_frame)
			id_cnt <= id_cnt + 1'b1;
	end

	// row content: fresh id on frame 0, calc result otherwise
	always_comb begin
		board_row.fallback = 1'b0;
		if (first_frame) begin
			board_row.best   = '{score: '0, id: id_cnt + 1'b1};
			board_row.second = empty_cand;
		end else begin
			board_row.best   = best;
			board_row.second = second;
		end
	end

endmodule

// File: hdl/oflow_score_board.sv
/* per-row candidate store: registration write, CR fallback write,
   registered CR read port */
module oflow_score_board (
	input  logic                                  clk,
	input  logic                                  rst_n,
	input  logic                                  we,
	input  logic [oflow_feature_pkg::row_len-1:0] wr_row,
	input  oflow_score_pkg::board_row_t           wr_data,
	input  logic                                  cr_we,
	input  logic [oflow_feature_pkg::row_len-1:0] cr_wr_row,
	input  logic                                  cr_fallback,
	input  logic [oflow_feature_pkg::row_len-1:0] cr_rd_row,
	output oflow_score_pkg::board_row_t           cr_rd_data
);
	import oflow_feature_pkg::*;
	import oflow_score_pkg::*;

	// --------------------------------------------------
	// row storage
	// --------------------------------------------------
	board_row_t rows [max_rows];

	logic [max_rows-1:0] reg_hit;   // registration write per row
	logic [max_rows-1:0] cr_hit;    // CR flag write per row

	// row decode for both writers
	always_comb begin
		for (int i = 0; i < max_rows; i++) begin
			reg_hit[i] = we && (wr_row == row_len'(i));
			cr_hit[i]  = cr_we && (cr_wr_row == row_len'(i));
		end
	end

	// registration replaces the row, CR only touches the flag
	// same row in one cycle -> registration wins
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < max_rows; i++)
				rows[i] <= empty_row;   // all ones scores, flag 0
		end else begin
			for (int i = 0; i < max_rows; i++) begin
				if (reg_hit[i]) begin
					rows[i].best     <= wr_data.best;
					rows[i].second   <= wr_data.second;
					rows[i].fallback <= 1'b0;   // fresh row, no fallback yet
				end else if (cr_hit[i]) begin
					rows[i].fallback <= cr_fallback;
				end
			end
		end
	end

	// --------------------------------------------------
	// CR read port
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cr_rd_data <= empty_row;
		end else begin
			cr_rd_data <= rows[cr_rd_row];   // data one cycle after row
		end
	end

endmodule

// File: hdl/oflow_score_calc.sv
/* two-stage similarity pipeline: weighted abs diffs, saturating sum,
   running best / second-best selection, history handshake */
module oflow_score_calc (
	input  logic                             clk,
	input  logic                             rst_n,
	input  logic                             start,
	input  oflow_feature_pkg::feature_t      cur_obj,
	input  oflow_score_pkg::weights_t        weights,
	input  logic                             hist_req,
	input  oflow_feature_pkg::hist_entry_t   hist_entry,
	input  logic                             hist_last,
	output logic                             hist_ack,
	output logic                             done,
	output oflow_score_pkg::cand_t           best,
	output oflow_score_pkg::cand_t           second
);
	import oflow_feature_pkg::*;
	import oflow_score_pkg::*;

	function automatic logic [score_len-1:0] abs_diff(input logic [score_len-1:0] a,
	                                                  input logic [score_len-1:0] b);
		return (a > b) ? a - b : b - a;
	endfunction

	logic                                busy;     // between start and last entry
	logic                                accept;   // entry taken this edge
	logic [score_len-1:0]                diff [num_terms];
	logic [score_len-1:0]                wgt  [num_terms];
	logic                                s1_valid;
	logic                                s1_last;
	logic [oflow_score_pkg::id_len-1:0]  s1_id;
	logic [score_len-1:0]                s1_term [num_terms];
	logic [score_len+2:0]                sum_wide; // room for five terms
	logic [score_len-1:0]                s2_score;

	// --------------------------------------------------
	// history handshake, four phase
	// --------------------------------------------------
	assign accept = busy && hist_req && !hist_ack;   // rising edge of hist_ack

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy     <= 1'b0;
			hist_ack <= 1'b0;
		end else begin
			if (start)
				busy <= 1'b1;
			else if (accept && hist_last)
				busy <= 1'b0;   // no more entries for this object
			if (accept)
				hist_ack <= 1'b1;
			else if (!hist_req)
				hist_ack <= 1'b0;   // source dropped req
		end
	end

	// --------------------------------------------------
	// stage 1: weighted absolute differences
	// --------------------------------------------------
	always_comb begin
		diff[0] = abs_diff(score_len'(cur_obj.cm_x), score_len'(hist_entry.feat.cm_x))
		        + abs_diff(score_len'(cur_obj.cm_y), score_len'(hist_entry.feat.cm_y));
		diff[1] = abs_diff(score_len'(cur_obj.width), score_len'(hist_entry.feat.width));
		diff[2] = abs_diff(score_len'(cur_obj.height), score_len'(hist_entry.feat.height));
		diff[3] = abs_diff(score_len'(cur_obj.color1), score_len'(hist_entry.feat.color1));
		diff[4] = abs_diff(score_len'(cur_obj.color2), score_len'(hist_entry.feat.color2));
		wgt[0]  = score_len'(weights.cm);
		wgt[1]  = score_len'(weights.w);
		wgt[2]  = score_len'(weights.h);
		wgt[3]  = score_len'(weights.color1);
		wgt[4]  = score_len'(weights.color2);
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			s1_valid <= 1'b0;
			s1_last  <= 1'b0;
		end else begin
			s1_valid <= accept;
			s1_last  <= accept && hist_last;
		end
	end

	// payload, loaded only on accept
	always_ff @(posedge clk) begin
		if (accept) begin
			s1_id <= hist_entry.id;
			for (int i = 0; i < num_terms; i++)
				s1_term[i] <= wgt[i] * diff[i];
		end
	end

	// --------------------------------------------------
	// stage 2: saturating sum and best / second insert
	// --------------------------------------------------
	always_comb begin
		sum_wide = '0;
		for (int i = 0; i < num_terms; i++)
			sum_wide = sum_wide + {3'b000, s1_term[i]};
		s2_score = (|sum_wide[score_len+2:score_len]) ? '1 : sum_wide[score_len-1:0];
	end

	always_ff @(posedge clk) begin
		if (!rst_n || start) begin
			best   <= empty_cand;
			second <= empty_cand;
			done   <= 1'b0;
		end else begin
			done <= s1_valid && s1_last;   // last entry leaves stage 2
			if (s1_valid) begin
				if (s2_score < best.score) begin   // strict, earlier wins a tie
					second <= best;
					best   <= '{score: s2_score, id: s1_id};
				end else if (s2_score < second.score) begin
					second <= '{score: s2_score, id: s1_id};
				end
			end
		end
	end

endmodule

// File: hdl/oflow_score_pkg.sv
/* score, id and weight widths, weight set,
   match candidate and score board row */
package oflow_score_pkg;

	// --------------------------------------------------
	// widths
	// --------------------------------------------------
	localparam int id_len        = 6;
	localparam int weight_len    = 4;   // per-feature weight
	localparam int score_len     = 16;  // saturates at all ones
	localparam int frame_num_len = 8;
	localparam int num_terms     = 5;   // cm, w, h, color1, color2

	// weights from the register file
	typedef struct packed {
		logic [weight_len-1:0] cm;
		logic [weight_len-1:0] w;
		logic [weight_len-1:0] h;
		logic [weight_len-1:0] color1;
		logic [weight_len-1:0] color2;
	} weights_t;

	// one match candidate, lower score is better
	typedef struct packed {
		logic [score_len-1:0] score;
		logic [id_len-1:0]    id;
	} cand_t;

	// score board row handed to the CR agent
	typedef struct packed {
		cand_t best;
		cand_t second;
		logic  fallback;   // set by CR when best is taken elsewhere
	} board_row_t;

	localparam cand_t empty_cand = '{score: '1, id: '0};   // no match yet
	localparam board_row_t empty_row = '{best: empty_cand, second: empty_cand, fallback: 1'b0};

endpackage

// File: oflow_reg.f
hdl/oflow_feature_pkg.sv
hdl/oflow_score_pkg.sv
hdl/oflow_feature_mem.sv
hdl/oflow_score_calc.sv
hdl/oflow_score_board.sv
hdl/oflow_registration_fsm.sv
hdl/oflow_registration.sv
verif/oflow_clk_gen.sv
verif/oflow_registration_sva.sv
verif/oflow_registration_tb.sv

// File: verif/oflow_clk_gen.sv
/* testbench clock, 100 ns period, and 5-cycle reset */
module oflow_clk_gen (
	output logic clk,
	output logic rst_n
);
	timeunit 1ns;
	timeprecision 100ps;

	localparam int half_period  = 50;
	localparam int reset_cycles = 5;

	initial begin
		clk = 1'b0;
		forever #half_period clk = ~clk;
	end

	initial begin
		rst_n = 1'b0;   // held over the first edges
		repeat (reset_cycles) @(posedge clk);
		rst_n <= 1'b1;
	end

endmodule

// File: verif/oflow_registration_sva.sv
/* concurrent checks on command and history handshakes,
   reset values and board row writes, bound into the top */
module oflow_registration_sva (
	input logic                                      clk,
	input logic                                      rst_n,
	input logic                                      reg_req,
	input logic                                      reg_ack,
	input logic [oflow_score_pkg::frame_num_len-1:0] frame_num,
	input logic                                      hist_req,
	input logic                                      hist_ack,
	input logic                                      calc_done,
	input logic                                      board_we,
	input oflow_score_pkg::board_row_t               board_row,
	input oflow_score_pkg::board_row_t               cr_rd_data
);
	timeunit 1ns;
	timeprecision 100ps;
	import oflow_score_pkg::*;

	int fail_cnt = 0;   // failed assertion count

	// --------------------------------------------------
	// reset values
	// --------------------------------------------------
	a_reset: assert property (@(posedge clk) !rst_n |=> !reg_ack && !hist_ack && !calc_done
		&& !board_we && cr_rd_data == empty_row)
	else begin
		$error("outputs not at reset values after reset");
		fail_cnt++;
	end

	// --------------------------------------------------
	// command handshake, four phase
	// --------------------------------------------------
	a_reg_rise: assert property (@(posedge clk) disable iff (!rst_n) $rose(reg_ack) |-> reg_req)
	else begin
		$error("reg_ack rose while reg_req was low");
		fail_cnt++;
	end
	a_reg_hold: assert property (@(posedge clk) disable iff (!rst_n) reg_ack && reg_req |=> reg_ack)
	else begin
		$error("reg_ack dropped while reg_req still high");
		fail_cnt++;
	end
	a_reg_fall: assert property (@(posedge clk) disable iff (!rst_n)
		$fell(reg_ack) |-> !$past(reg_req))
	else begin
		$error("reg_ack fell before reg_req was released");
		fail_cnt++;
	end
	// frame 0 skips scoring, ack 3 cycles after req
	a_frame0_ack: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(reg_ack) && frame_num == '0 |-> $past(reg_req, 3) && !$past(reg_req, 4))
	else begin
		$error("frame 0 reg_ack not 3 cycles after reg_req");
		fail_cnt++;
	end

	// --------------------------------------------------
	// history handshake
	// --------------------------------------------------
	a_hist_rise: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(hist_ack) |-> hist_req)
	else begin
		$error("hist_ack rose while hist_req was low");
		fail_cnt++;
	end
	a_hist_fall: assert property (@(posedge clk) disable iff (!rst_n)
		$fell(hist_ack) |-> !$past(hist_req))
	else begin
		$error("hist_ack fell before hist_req was released");
		fail_cnt++;
	end

	// scored row written by a registration, best ahead of second
	a_board_row: assert property (@(posedge clk) disable iff (!rst_n)
		board_we && frame_num != '0 |-> board_row.best.score <= board_row.second.score)
	else begin
		$error("board row write with second candidate ahead of best");
		fail_cnt++;
	end

endmodule

bind oflow_registration oflow_registration_sva oflow_registration_sva_i (
	.clk(clk), .rst_n(rst_n), .reg_req(reg_req), .reg_ack(reg_ack), .frame_num(frame_num),
	.hist_req(hist_req), .hist_ack(hist_ack), .calc_done(calc_done), .board_we(board_we),
	.board_row(board_row), .cr_rd_data(cr_rd_data)
);

// File: verif/oflow_registration_tb.sv
/* registration unit testbench: stimulus, reference scoring model,
   per-test report lines and watchdog */
module oflow_registration_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import oflow_feature_pkg::*;
	import oflow_score_pkg::*;

	localparam int handshakes = 16 + 20 + 8 + 19 + 20;   // regs, entries, reads per test
	localparam int cycles_per_handshake = 20;
	localparam cand_t no_match = '{score: 16'hffff, id: 6'd0};

	logic                     clk;
	logic                     rst_n;
	weights_t                 weights;
	logic                     reg_req;
	logic                     reg_ack;
	feature_t                 cur_obj;
	logic [row_len-1:0]       row;
	logic [frame_num_len-1:0] frame_num;
	logic                     hist_req;
	hist_entry_t              hist_entry;
	logic                     hist_last;
	logic                     hist_ack;
	logic [row_len-1:0]       cr_rd_row;
	board_row_t               cr_rd_data;
	logic                     cr_we;
	logic [row_len-1:0]       cr_wr_row;
	logic                     cr_fallback;
	logic [row_len-1:0]       fe_rd_row;
	feature_t                 fe_rd_data;

	integer             seed = 32'hd395;
	string              test_name;
	int                 test_num = 0;
	int                 test_errs = 0;
	int                 failed_tests = 0;
	int                 sva_seen = 0;     // assertion failures already booked
	feature_t           stored_obj [max_rows];
	board_row_t         exp_rows [max_rows];
	hist_entry_t        hist_set [2][5];  // five entries per scored object
	feature_t           saved_obj [2];
	logic [row_len-1:0] saved_row [2];

	oflow_clk_gen oflow_clk_gen_i (.clk(clk), .rst_n(rst_n));

	oflow_registration oflow_registration_i (.*);

	// --------------------------------------------------
	// reference model
	// --------------------------------------------------
	function automatic int abs_dist(input int a, input int b);
		return (a > b) ? a - b : b - a;
	endfunction

	// weighted sum of absolute differences, clipped to 16 bits
	function automatic logic [15:0] model_score(input feature_t a, input feature_t b);
		int sum;
		sum = int'(weights.cm) * (abs_dist(int'(a.cm_x), int'(b.cm_x))
		    + abs_dist(int'(a.cm_y), int'(b.cm_y)))
		    + int'(weights.w) * abs_dist(int'(a.width), int'(b.width))
		    + int'(weights.h) * abs_dist(int'(a.height), int'(b.height))
		    + int'(weights.color1) * abs_dist(int'(a.color1), int'(b.color1))
		    + int'(weights.color2) * abs_dist(int'(a.color2), int'(b.color2));
		return (sum > 65535) ? 16'hffff : sum[15:0];
	endfunction

	function automatic board_row_t model_match(input feature_t obj, input int set);
		board_row_t m;
		logic [15:0] sc;
		m = '{best: no_match, second: no_match, fallback: 1'b0};
		for (int i = 0; i < 5; i++) begin
			sc = model_score(obj, hist_set[set][i].feat);
			if (sc < m.best.score) begin   // strict, so a tie keeps the earlier entry
				m.second = m.best;
				m.best = '{score: sc, id: hist_set[set][i].id};
			end else if (sc < m.second.score) begin
				m.second = '{score: sc, id: hist_set[set][i].id};
			end
		end
		return m;
	endfunction

	function automatic feature_t random_feature();
		logic [63:0] r;
		r = {$random(seed), $random(seed)};
		return r[49:0];
	endfunction

	// --------------------------------------------------
	// checks and reporting
	// --------------------------------------------------
	task automatic check_equal(input logic [63:0] expected, input logic [63:0] actual);
		assert (actual === expected)
		else begin
			$display("CHECK FAILED %s: expected %h, actual %h", test_name, expected, actual);
			test_errs++;
		end
	endtask

	task automatic finish_test();
		int sva_now;
		sva_now = oflow_registration_i.oflow_registration_sva_i.fail_cnt;
		test_errs += sva_now - sva_seen;   // bound assertions count against this test
		sva_seen = sva_now;
		test_num++;
		$display("test %0d %s: %s, %0d failures", test_num, test_name,
		         (test_errs == 0) ? "pass" : "fail", test_errs);
		if (test_errs != 0)
			failed_tests++;
		test_errs = 0;
	endtask

	// --------------------------------------------------
	// bus tasks, drive on rising edge, sample on falling
	// --------------------------------------------------
	task automatic register_object(input feature_t obj, input logic [row_len-1:0] r,
	                               input logic [frame_num_len-1:0] frame);
		@(posedge clk);
		cur_obj <= obj;
		row <= r;
		frame_num <= frame;
		reg_req <= 1'b1;
		do @(negedge clk); while (!reg_ack);
		@(posedge clk);
		reg_req <= 1'b0;
		do @(negedge clk); while (reg_ack);
	endtask

	task automatic feed_history(input int set, input logic stretch);
		int hold;
		for (int i = 0; i < 5; i++) begin
			hold = stretch ? ($random(seed) & 7) : 0;
			@(posedge clk);
			hist_entry <= hist_set[set][i];
			hist_last <= (i == 4);
			hist_req <= 1'b1;
			do @(negedge clk); while (!hist_ack);
			repeat (hold) @(posedge clk);   // slow source keeps req up
			@(posedge clk);
			hist_req <= 1'b0;
			do @(negedge clk); while (hist_ack);
		end
	endtask

	task automatic cr_write(input logic [row_len-1:0] r, input logic flag);
		cr_we <= 1'b1;   // caller sits on a rising edge
		cr_wr_row <= r;
		cr_fallback <= flag;
		@(posedge clk);
		cr_we <= 1'b0;
	endtask

	task automatic read_feature(input logic [row_len-1:0] r, output feature_t data);
		@(posedge clk);
		fe_rd_row <= r;
		@(posedge clk);
		@(negedge clk);
		data = fe_rd_data;
	endtask

	task automatic check_board_rows();
		board_row_t got;
		for (int r = 0; r < max_rows; r++) begin
			@(posedge clk);
			cr_rd_row <= row_len'(r);
			@(posedge clk);
			@(negedge clk);
			got = cr_rd_data;   // one cycle read latency
			check_equal(64'(exp_rows[r]), 64'(got));
		end
	endtask

	// --------------------------------------------------
	// test sequence
	// --------------------------------------------------
	initial begin
		feature_t got_feat;
		feature_t obj;
		weights = '{cm: 4'd3, w: 4'd2, h: 4'd2, color1: 4'd1, color2: 4'd4};
		reg_req = 1'b0;
		cur_obj = '0;
		row = '0;
		frame_num = '0;
		hist_req = 1'b0;
		hist_entry = '0;
		hist_last = 1'b0;
		cr_rd_row = '0;
		cr_we = 1'b0;
		cr_wr_row = '0;
		cr_fallback = 1'b0;
		fe_rd_row = '0;
		wait (rst_n);

		test_name = "frame_zero_ids";
		for (int r = 0; r < max_rows; r++) begin
			stored_obj[r] = random_feature();
			register_object(stored_obj[r], row_len'(r), 8'd0);
			exp_rows[r] = '{best: '{score: 16'd0, id: 6'(r + 1)}, second: no_match, fallback: 1'b0};
		end
		check_board_rows();
		finish_test();

		test_name = "history_scoring";
		for (int k = 0; k < 2; k++) begin
			saved_obj[k] = random_feature();
			saved_row[k] = row_len'(3 * k + 3);   // rows 3 and 6
			for (int i = 0; i < 5; i++)
				hist_set[k][i] = '{feat: random_feature(), id: 6'($random(seed))};
			hist_set[k][3].feat = hist_set[k][1].feat;   // tie with an earlier entry
			hist_set[k][4].feat = saved_obj[k];          // exact match, score 0
			stored_obj[saved_row[k]] = saved_obj[k];
			exp_rows[saved_row[k]] = model_match(saved_obj[k], k);
			fork
				register_object(saved_obj[k], saved_row[k], 8'd1);
				feed_history(k, 1'b0);
			join
		end
		check_board_rows();
		finish_test();

		test_name = "feature_readback";
		for (int r = 0; r < max_rows; r++) begin
			read_feature(row_len'(r), got_feat);
			check_equal(64'(stored_obj[r]), 64'(got_feat));
		end
		finish_test();

		test_name = "cr_fallback";
		@(posedge clk);
		cr_write(3'd2, 1'b1);
		exp_rows[2].fallback = 1'b1;   // only row 2 flagged
		check_board_rows();
		obj = random_feature();
		stored_obj[2] = obj;
		exp_rows[2] = '{best: '{score: 16'd0, id: 6'd9}, second: no_match, fallback: 1'b0};
		fork
			register_object(obj, 3'd2, 8'd0);
			begin
				repeat (3) @(posedge clk);   // CR write on the board write edge
				cr_write(3'd2, 1'b1);
			end
		join
		check_board_rows();
		finish_test();

		test_name = "backpressure";
		for (int k = 0; k < 2; k++) begin
			fork
				register_object(saved_obj[k], saved_row[k], 8'd1);
				feed_history(k, 1'b1);
			join
		end
		check_board_rows();   // same rows as the unstretched run
		finish_test();

		$display("%0d tests run, %0d failed", test_num, failed_tests);
		if (failed_tests == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

	// watchdog sized from the handshake count
	initial begin
		repeat (handshakes * cycles_per_handshake) @(posedge clk);
		$display("watchdog expired after %0d cycles, a handshake never completed",
		         handshakes * cycles_per_handshake);
		$display("Test FAILED");
		$finish;
	end

endmodule
